/* core_debug_unit.f */
hdl/riscv_pkg.sv
hdl/dbg_pkg.sv
hdl/gpr_file.sv
hdl/dbg_halt_fsm.sv
hdl/abstract_reg_access.sv
hdl/core_debug_unit.sv
test/tb_clock_gen.sv
test/core_debug_unit_sva.sv
test/core_debug_unit_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = core_debug_unit_tb
FILELIST = core_debug_unit.f
LOG      = sim.log
FAIL_MSG = Test failures found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"
	@echo "  help   show this list"

# a run stopped by a failed assertion exits nonzero without the summary
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* test/core_debug_unit_tb.sv */
`timescale 1ns/10ps

module core_debug_unit_tb import riscv_pkg::*, dbg_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int WATCHDOG_CYCLES = 2000;   // all tests need about 100 cycles

    logic        clk;
    logic        reset_n;
    logic        retire_valid_i, retire_jump_i, ebreak_i, pipe_empty_i;
    logic        wb_en_i, haltreq_i, resumereq_i, ar_en_i, ar_wr_i;
    logic        running_o, halted_o, resumeack_o, ar_done_o;
    xlen_t       retire_pc_i, retire_target_i, wb_data_i, ar_wdata_i;
    xlen_t       core_rdata_o, resume_pc_o, ar_rdata_o;
    reg_addr_t   wb_addr_i, core_raddr_i;
    ar_addr_t    ar_addr_i;

    int          error_count;
    logic [31:0] lfsr_state;
    xlen_t       gpr_model [32];   // expected register contents

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    core_debug_unit #(.NUM_REGS(32)) UUT (.*);

    // ============================================================
    // helpers
    // ============================================================

    // galois lfsr stepped once per bit taken
    function automatic xlen_t next_random(input int nbits);
        xlen_t value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'ha300_0000 : lfsr_state >> 1;
            value      = {value[XLEN-2:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // xdebugver 4, cause, machine privilege
    function automatic xlen_t expected_dcsr(input halt_cause_t cause);
        return (xlen_t'(4) << 28) | (xlen_t'(cause) << 6) | xlen_t'(3);
    endfunction

    task automatic check_word(input string name, input string what, input xlen_t expected,
                              input xlen_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s: %s expected %08h actual %08h", name, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s: %s expected %b actual %b", name, what, expected, actual);
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // write data or read and compare against data
    task automatic ar_access(input string name, input logic wr, input ar_addr_t addr,
                             input xlen_t data);
        ar_en_i    = 1'b1;
        ar_wr_i    = wr;
        ar_addr_i  = addr;
        ar_wdata_i = data;
        #1;
        check_bit(name, "ar_done_o", 1'b1, ar_done_o);
        if (!wr) begin
            check_word(name, $sformatf("abstract read %04h", addr), data, ar_rdata_o);
        end
        wait_cycle();   // a write lands at this edge
        ar_en_i = 1'b0;
        ar_wr_i = 1'b0;
    endtask

    task automatic core_expect(input string name, input reg_addr_t addr);
        core_raddr_i = addr;
        #1;
        check_word(name, $sformatf("core read x%0d", addr), gpr_model[addr], core_rdata_o);
        wait_cycle();
    endtask

    // ============================================================
    // tests
    // ============================================================

    task automatic reset_state_test();
        check_bit("reset_state", "running_o", 1'b1, running_o);
        check_bit("reset_state", "halted_o", 1'b0, halted_o);
        check_bit("reset_state", "resumeack_o", 1'b0, resumeack_o);
        repeat (6) begin
            core_expect("reset_state", reg_addr_t'(next_random(REG_ADDR_W)));
        end
    endtask

    task automatic writeback_test();
        reg_addr_t idx;
        for (int n = 0; n < 9; n++) begin
            idx       = (n == 8) ? reg_addr_t'(0) : reg_addr_t'(next_random(REG_ADDR_W));
            wb_en_i   = 1'b1;
            wb_addr_i = idx;
            wb_data_i = next_random(XLEN);
            if (idx != '0) begin
                gpr_model[idx] = wb_data_i;   // x0 stays zero
            end
            wait_cycle();
            wb_en_i = 1'b0;
            core_expect("writeback", idx);
        end
    endtask

    task automatic halt_request_test();
        xlen_t pc;
        logic  jump;
        xlen_t target;
        xlen_t next_pc;
        pipe_empty_i = 1'b1;
        for (int n = 0; n < 6; n++) begin
            pc     = next_random(30) << 2;
            jump   = (next_random(1) != '0);
            target = next_random(30) << 2;
            if (jump) begin
                next_pc = target;
            end else begin
                next_pc = pc + 32'd4;   // sequential, next word
            end
            retire_valid_i  = 1'b1;
            retire_pc_i     = pc;
            retire_jump_i   = jump;
            retire_target_i = target;
            wait_cycle();
        end
        retire_valid_i = 1'b0;
        haltreq_i      = 1'b1;
        wait_cycle();
        haltreq_i = 1'b0;
        check_bit("halt_request", "halted_o one clock after request", 1'b0, halted_o);
        wait_cycle();
        check_bit("halt_request", "halted_o two clocks after request", 1'b1, halted_o);
        ar_access("halt_request", 1'b0, CSR_DPC, next_pc);
        ar_access("halt_request", 1'b0, CSR_DCSR, expected_dcsr(3'd3));
    endtask

    task automatic halted_access_test();
        reg_addr_t idx;
        xlen_t     data;
        for (int n = 0; n < 8; n++) begin
            idx  = (n == 0) ? reg_addr_t'(0) : reg_addr_t'(next_random(REG_ADDR_W));
            data = next_random(XLEN);
            ar_access("halted_access", 1'b1, AR_GPR_BASE + ar_addr_t'(idx), data);
            if (idx != '0) begin
                gpr_model[idx] = data;
            end
            ar_access("halted_access", 1'b0, AR_GPR_BASE + ar_addr_t'(idx), gpr_model[idx]);
            core_expect("halted_access", idx);
        end
        ar_access("halted_access", 1'b0, CSR_MSTATUS, 32'h0000_1800);
        ar_access("halted_access", 1'b0, CSR_MISA, 32'h4000_0100);
        ar_access("halted_access", 1'b0, AR_GPR_BASE + 16'd32, '0);   // one past x31
        ar_access("halted_access", 1'b0, 16'h0400, '0);
    endtask

    task automatic resume_test();
        xlen_t     new_dpc;
        reg_addr_t idx;
        new_dpc = next_random(30) << 2;
        ar_access("resume", 1'b1, CSR_DPC, new_dpc);
        resumereq_i = 1'b1;
        wait_cycle();
        resumereq_i = 1'b0;
        check_bit("resume", "resumeack_o", 1'b1, resumeack_o);
        check_word("resume", "resume_pc_o", new_dpc, resume_pc_o);
        wait_cycle();
        check_bit("resume", "resumeack_o after one cycle", 1'b0, resumeack_o);
        check_bit("resume", "running_o", 1'b1, running_o);
        // running again so the write must be dropped
        idx = reg_addr_t'(next_random(REG_ADDR_W)) | 5'd1;
        ar_access("resume", 1'b1, AR_GPR_BASE + ar_addr_t'(idx), next_random(XLEN));
        ar_access("resume", 1'b0, AR_GPR_BASE + ar_addr_t'(idx), gpr_model[idx]);
        core_expect("resume", idx);
    endtask

    task automatic ebreak_halt_test();
        xlen_t pc;
        int    waited;
        pc             = next_random(30) << 2;
        pipe_empty_i   = 1'b0;
        retire_valid_i = 1'b1;
        retire_pc_i    = pc;
        retire_jump_i  = 1'b0;
        ebreak_i       = 1'b1;
        wait_cycle();
        retire_valid_i = 1'b0;
        ebreak_i       = 1'b0;
        repeat (4) begin
            wait_cycle();
            check_bit("ebreak_halt", "halted_o while pipeline busy", 1'b0, halted_o);
        end
        pipe_empty_i = 1'b1;
        waited       = 0;
        while (halted_o !== 1'b1 && waited < 4) begin
            wait_cycle();
            waited++;
        end
        if (halted_o !== 1'b1) begin
            error_count++;
            $display("ebreak_halt: core did not halt after the pipeline drained");
        end
        ar_access("ebreak_halt", 1'b0, CSR_DPC, pc);
        ar_access("ebreak_halt", 1'b0, CSR_DCSR, expected_dcsr(3'd1));
    endtask

    // ============================================================
    // run
    // ============================================================

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d clock periods", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        retire_valid_i  = 1'b0;
        retire_jump_i   = 1'b0;
        retire_pc_i     = '0;
        retire_target_i = '0;
        ebreak_i        = 1'b0;
        pipe_empty_i    = 1'b1;   // idle pipeline
        wb_en_i         = 1'b0;
        wb_addr_i       = '0;
        wb_data_i       = '0;
        core_raddr_i    = '0;
        haltreq_i       = 1'b0;
        resumereq_i     = 1'b0;
        ar_en_i         = 1'b0;
        ar_wr_i         = 1'b0;
        ar_addr_i       = '0;
        ar_wdata_i      = '0;
        error_count     = 0;
        lfsr_state      = 32'h4fcf_9da6;
        for (int i = 0; i < 32; i++) begin
            gpr_model[i] = '0;
        end
        @(posedge reset_n);
        wait_cycle();
        reset_state_test();
        writeback_test();
        halt_request_test();
        halted_access_test();
        resume_test();
        ebreak_halt_test();
        $display("checks done, %0d error(s)", error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* test/core_debug_unit_sva.sv */
`timescale 1ns/10ps

module core_debug_unit_sva (
    input logic clk,
    input logic reset_n,
    input logic running_i,
    input logic halted_i,
    input logic resumeack_i,
    input logic ar_en_i,
    input logic ar_done_i
);

    // resume ack is a single-cycle pulse
    a_resumeack_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        resumeack_i |=> !resumeack_i)
        else $error("resumeack_o stayed high for more than one cycle");

    a_state_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(running_i && halted_i))
        else $error("running_o and halted_o are high together");

    // every access completes in the cycle it is presented
    a_done_follows_en: assert property (@(posedge clk) disable iff (!reset_n)
        ar_done_i == ar_en_i)
        else $error("ar_done_o does not follow ar_en_i");

endmodule

bind core_debug_unit core_debug_unit_sva u_sva (
    .clk         (clk),
    .reset_n     (reset_n),
    .running_i   (running_o),
    .halted_i    (halted_o),
    .resumeack_i (resumeack_o),
    .ar_en_i     (ar_en_i),
    .ar_done_i   (ar_done_o)
);

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
)(
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released between edges so the first active edge is clean
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

/* hdl/core_debug_unit.sv */
`timescale 1ns/10ps

module core_debug_unit import riscv_pkg::*, dbg_pkg::*; #(
    parameter int NUM_REGS = NUM_REGS_DEFAULT
)(
    input  logic      clk,
    input  logic      reset_n,
    // retire side
    input  logic      retire_valid_i,
    input  xlen_t     retire_pc_i,
    input  logic      retire_jump_i,
    input  xlen_t     retire_target_i,
    input  logic      ebreak_i,
    input  logic      pipe_empty_i,
    // write-back and core read
    input  logic      wb_en_i,
    input  reg_addr_t wb_addr_i,
    input  xlen_t     wb_data_i,
    input  reg_addr_t core_raddr_i,
    output xlen_t     core_rdata_o,
    // debugger
    input  logic      haltreq_i,
    input  logic      resumereq_i,
    output logic      running_o,
    output logic      halted_o,
    output logic      resumeack_o,
    output xlen_t     resume_pc_o,
    input  logic      ar_en_i,
    input  logic      ar_wr_i,
    input  ar_addr_t  ar_addr_i,
    input  xlen_t     ar_wdata_i,
    output xlen_t     ar_rdata_o,
    output logic      ar_done_o
);

    xlen_t     dpc;
    xlen_t     dcsr;
    logic      dpc_we;
    logic      gpr_we;
    reg_addr_t gpr_addr;
    xlen_t     ar_wdata;   // shared by dpc and gpr writes
    xlen_t     gpr_rdata;

    // ============================================================
    // halt control, access decode, register file
    // ============================================================

    dbg_halt_fsm u_dbg_halt_fsm (
        .clk             (clk),
        .reset_n         (reset_n),
        .haltreq_i       (haltreq_i),
        .resumereq_i     (resumereq_i),
        .ebreak_i        (ebreak_i),
        .retire_valid_i  (retire_valid_i),
        .retire_jump_i   (retire_jump_i),
        .pipe_empty_i    (pipe_empty_i),
        .retire_pc_i     (retire_pc_i),
        .retire_target_i (retire_target_i),
        .dpc_we_i        (dpc_we),
        .dpc_wdata_i     (ar_wdata),
        .running_o       (running_o),
        .halted_o        (halted_o),
        .resumeack_o     (resumeack_o),
        .dpc_o           (dpc),
        .dcsr_o          (dcsr),
        .resume_pc_o     (resume_pc_o)
    );

    abstract_reg_access #(
        .NUM_REGS (NUM_REGS)
    ) u_abstract_reg_access (
        .ar_en_i     (ar_en_i),
        .ar_wr_i     (ar_wr_i),
        .ar_addr_i   (ar_addr_i),
        .ar_wdata_i  (ar_wdata_i),
        .ar_rdata_o  (ar_rdata_o),
        .ar_done_o   (ar_done_o),
        .halted_i    (halted_o),
        .dpc_i       (dpc),
        .dcsr_i      (dcsr),
        .gpr_rdata_i (gpr_rdata),
        .dpc_we_o    (dpc_we),
        .gpr_we_o    (gpr_we),
        .gpr_addr_o  (gpr_addr),
        .wdata_o     (ar_wdata)
    );

    gpr_file #(
        .NUM_REGS (NUM_REGS)
    ) u_gpr_file (
        .clk          (clk),
        .reset_n      (reset_n),
        .wb_en_i      (wb_en_i),
        .wb_addr_i    (wb_addr_i),
        .wb_data_i    (wb_data_i),
        .core_raddr_i (core_raddr_i),
        .core_rdata_o (core_rdata_o),
        .dbg_we_i     (gpr_we),
        .dbg_addr_i   (gpr_addr),
        .dbg_wdata_i  (ar_wdata),
        .dbg_rdata_o  (gpr_rdata),
        .halted_i     (halted_o)   // blocks write-back while halted
    );

endmodule

/* hdl/abstract_reg_access.sv */
`timescale 1ns/10ps

module abstract_reg_access import riscv_pkg::*, dbg_pkg::*; #(
    parameter int NUM_REGS = NUM_REGS_DEFAULT
)(
    // debugger access port
    input  logic      ar_en_i,
    input  logic      ar_wr_i,
    input  ar_addr_t  ar_addr_i,
    input  xlen_t     ar_wdata_i,
    output xlen_t     ar_rdata_o,
    output logic      ar_done_o,
    // from the halt fsm
    input  logic      halted_i,
    input  xlen_t     dpc_i,
    input  xlen_t     dcsr_i,
    // register file
    input  xlen_t     gpr_rdata_i,
    output logic      dpc_we_o,
    output logic      gpr_we_o,
    output reg_addr_t gpr_addr_o,
    output xlen_t     wdata_o
);

    ar_addr_t gpr_offset;   // number relative to x0
    logic     is_gpr;
    logic     wr_ok;

    // ============================================================
    // address decode
    // ============================================================

    assign gpr_offset = ar_addr_i - AR_GPR_BASE;
    assign is_gpr     = (ar_addr_i >= AR_GPR_BASE) && (int'(gpr_offset) < NUM_REGS);
    assign gpr_addr_o = gpr_offset[REG_ADDR_W-1:0];

    // read mux
    always_comb begin
        if (is_gpr) begin
            ar_rdata_o = gpr_rdata_i;
        end else begin
            case (ar_addr_i)
                CSR_DCSR:    ar_rdata_o = dcsr_i;
                CSR_DPC:     ar_rdata_o = dpc_i;
                CSR_MSTATUS: ar_rdata_o = MSTATUS_VALUE;
                CSR_MISA:    ar_rdata_o = MISA_VALUE;
                default:     ar_rdata_o = '0;   // unmapped
            endcase
        end
    end

    // ============================================================
    // writes, only while halted
    // ============================================================

    assign wr_ok    = ar_en_i && ar_wr_i && halted_i;
    assign dpc_we_o = wr_ok && (ar_addr_i == CSR_DPC);
    assign gpr_we_o = wr_ok && is_gpr;   // x0 dropped in the file
    assign wdata_o  = ar_wdata_i;

    // every access completes in the cycle it is presented
    assign ar_done_o = ar_en_i;

endmodule

/* hdl/dbg_halt_fsm.sv */
`timescale 1ns/10ps

module dbg_halt_fsm import riscv_pkg::*, dbg_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    // debugger requests
    input  logic  haltreq_i,
    input  logic  resumereq_i,
    // retire side of the core
    input  logic  ebreak_i,
    input  logic  retire_valid_i,
    input  logic  retire_jump_i,
    input  logic  pipe_empty_i,
    input  xlen_t retire_pc_i,
    input  xlen_t retire_target_i,
    // dpc write from abstract access
    input  logic  dpc_we_i,
    input  xlen_t dpc_wdata_i,
    // status
    output logic  running_o,
    output logic  halted_o,
    output logic  resumeack_o,
    output xlen_t dpc_o,
    output xlen_t dcsr_o,
    output xlen_t resume_pc_o
);

    localparam logic [1:0] PRV_M = 2'b11;

    dbg_state_e  state_q;
    xlen_t       next_pc_q;   // pc of the first instruction not yet retired
    xlen_t       next_pc_d;
    xlen_t       dpc_q;
    halt_cause_t cause_q;

    // ============================================================
    // next pc from the retire stream
    // ============================================================

    always_comb begin
        next_pc_d = next_pc_q;
        if (retire_valid_i && !ebreak_i) begin
            next_pc_d = retire_jump_i ? retire_target_i : retire_pc_i + 32'd4;
        end
    end

    // ============================================================
    // halt / resume state machine
    // ============================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= ST_RUNNING;
            next_pc_q <= '0;
            dpc_q     <= '0;
            cause_q   <= '0;
        end else begin
            case (state_q)
                ST_RUNNING: begin
                    if (retire_valid_i && ebreak_i) begin
                        state_q <= ST_HALTING;
                        dpc_q   <= retire_pc_i;   // ebreak itself is not executed
                        cause_q <= CAUSE_EBREAK;
                    end else begin
                        next_pc_q <= next_pc_d;
                        if (haltreq_i) begin
                            state_q <= ST_HALTING;
                            dpc_q   <= next_pc_d;
                            cause_q <= CAUSE_HALTREQ;
                        end
                    end
                end
                ST_HALTING: begin
                    next_pc_q <= next_pc_d;   // pipeline still draining
                    if (cause_q == CAUSE_HALTREQ) begin
                        dpc_q <= next_pc_d;
                    end
                    if (pipe_empty_i) begin
                        state_q <= ST_HALTED;
                    end
                end
                ST_HALTED: begin
                    if (dpc_we_i) begin
                        dpc_q <= dpc_wdata_i;
                    end
                    if (resumereq_i) begin
                        state_q <= ST_RESUMING;
                    end
                end
                ST_RESUMING: begin
                    next_pc_q <= dpc_q;   // core restarts at dpc
                    state_q   <= ST_RUNNING;
                end
                default: state_q <= ST_RUNNING;
            endcase
        end
    end

    assign running_o   = (state_q == ST_RUNNING);
    assign halted_o    = (state_q == ST_HALTED);
    assign resumeack_o = (state_q == ST_RESUMING);

    // xdebugver | cause | prv
    assign dcsr_o      = {DCSR_XDEBUGVER, 19'b0, cause_q, 4'b0, PRV_M};
    assign dpc_o       = dpc_q;
    assign resume_pc_o = dpc_q;

endmodule

/* hdl/gpr_file.sv */
`timescale 1ns/10ps

module gpr_file import riscv_pkg::*; #(
    parameter int NUM_REGS = NUM_REGS_DEFAULT
)(
    input  logic      clk,
    input  logic      reset_n,
    // core write-back
    input  logic      wb_en_i,
    input  reg_addr_t wb_addr_i,
    input  xlen_t     wb_data_i,
    // core read
    input  reg_addr_t core_raddr_i,
    output xlen_t     core_rdata_o,
    // debugger side
    input  logic      dbg_we_i,
    input  reg_addr_t dbg_addr_i,
    input  xlen_t     dbg_wdata_i,
    output xlen_t     dbg_rdata_o,
    input  logic      halted_i
);

    xlen_t regs [NUM_REGS];

    // x0 and indices past the end are never written
    function automatic logic writable(input reg_addr_t addr);
        return (addr != '0) && (int'(addr) < NUM_REGS);
    endfunction

    function automatic logic readable(input reg_addr_t addr);
        return (addr != '0) && (int'(addr) < NUM_REGS);
    endfunction

    // ============================================================
    // write ports
    // ============================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (dbg_we_i) begin   // debugger wins
            if (writable(dbg_addr_i)) begin
                regs[dbg_addr_i] <= dbg_wdata_i;
            end
        end else if (wb_en_i && !halted_i && writable(wb_addr_i)) begin
            regs[wb_addr_i] <= wb_data_i;   // core frozen while halted
        end
    end

    // read ports, combinational
    assign core_rdata_o = readable(core_raddr_i) ? regs[core_raddr_i] : '0;
    assign dbg_rdata_o  = readable(dbg_addr_i) ? regs[dbg_addr_i] : '0;

endmodule

/* hdl/dbg_pkg.sv */
package dbg_pkg;

    import riscv_pkg::*;

    // ============================================================
    // abstract register numbers
    // ============================================================

    typedef logic [15:0] ar_addr_t;

    localparam ar_addr_t CSR_MSTATUS = 16'h0300;
    localparam ar_addr_t CSR_MISA    = 16'h0301;
    localparam ar_addr_t CSR_DCSR    = 16'h07b0;
    localparam ar_addr_t CSR_DPC     = 16'h07b1;
    localparam ar_addr_t AR_GPR_BASE = 16'h1000;   // x0, gprs follow in order

    // read-only words, no backing register
    localparam xlen_t MSTATUS_VALUE = 32'h0000_1800;   // mpp = machine
    localparam xlen_t MISA_VALUE    = 32'h4000_0100;   // mxl = 32, I only

    // ============================================================
    // dcsr fields
    // ============================================================

    typedef logic [2:0] halt_cause_t;

    localparam halt_cause_t CAUSE_EBREAK  = 3'd1;
    localparam halt_cause_t CAUSE_HALTREQ = 3'd3;

    localparam logic [3:0] DCSR_XDEBUGVER = 4'd4;   // external debug support

    // halt/resume states
    typedef enum logic [1:0] {
        ST_RUNNING,
        ST_HALTING,   // waiting for the pipeline to drain
        ST_HALTED,
        ST_RESUMING   // single cycle, acks the resume
    } dbg_state_e;

endpackage

/* hdl/riscv_pkg.sv */
package riscv_pkg;

    // ============================================================
    // base rv32 widths
    // ============================================================

    localparam int XLEN       = 32;   // integer register width
    localparam int REG_ADDR_W = 5;    // x0..x31

    // data word for register values, pcs and csr contents
    typedef logic [XLEN-1:0] xlen_t;

    // integer register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ============================================================
    // register file sizing
    // ============================================================

    // 32 for rv32i, 16 gives an rv32e sized file
    localparam int NUM_REGS_DEFAULT = 32;

endpackage
